//--- design/mac_booth_sel.sv
/*
 * radix-4 booth selector for one digit
 * picks 0, +-1 or +-2 times the source at 16 or 8 bits
 * top bit comes out inverted so rows need no sign extension,
 * negative multiples are one's complement with sel_inv for the +1
 */

`default_nettype none
`timescale 1ns/1ns

module mac_booth_sel (
  input  wire logic [mac_mul_pkg::DIGIT_W-1:0] code,
  input  wire logic                            is_int8,
  input  wire mac_mul_pkg::mul_operand_u       src,
  output logic [mac_mul_pkg::SEL_W-1:0]        sel_data,
  output logic                                 sel_inv
);

  logic                                  dig_one;   // |digit| == 1
  logic                                  dig_two;   // |digit| == 2
  logic                                  dig_neg;   // negative, 111 counts as +0
  logic [mac_mul_pkg::SEL_W-1:0]         mag_16;    // 17-bit signed multiple
  logic [mac_mul_pkg::LANE_W:0]          mag_8;     // 9-bit signed multiple

  // digit = -2*c2 + c1 + c0
  assign dig_one = code[1] ^ code[0];
  assign dig_two = (code == 3'b011) | (code == 3'b100);
  assign dig_neg = code[2] & ~(code[1] & code[0]);

  always_comb begin
    mag_16 = '0;
    mag_8  = '0;
    if (dig_one) begin
      mag_16 = {src.word[15], src.word};
      mag_8  = {src.lanes.lo[7], src.lanes.lo};
    end else if (dig_two) begin
      mag_16 = {src.word, 1'b0};
      mag_8  = {src.lanes.lo, 1'b0};
    end
  end

  always_comb begin
    if (is_int8) begin
      // upper byte idle in int8
      sel_data = {{(mac_mul_pkg::SEL_W - mac_mul_pkg::LANE_W - 1){1'b0}},
                  (mag_8 ^ {(mac_mul_pkg::LANE_W + 1){dig_neg}}) ^ 9'h100};
    end else begin
      sel_data = (mag_16 ^ {mac_mul_pkg::SEL_W{dig_neg}}) ^ 17'h1_0000;
    end
    sel_inv = dig_neg;  // +1 lands in the next row
  end

endmodule

`default_nettype wire

//--- design/mac_cfg_op.sv
/*
 * input side of the multiplier lane
 * mode register, lane valids, booth digit windows from operand a
 * and the per-group source words from operand b
 */

`default_nettype none
`timescale 1ns/1ns

module mac_cfg_op (
  input  wire logic                      nvdla_core_clk,
  input  wire logic                      nvdla_core_rstn,
  input  wire logic                      cfg_is_int8,
  input  wire logic                      cfg_reg_en,
  input  wire mac_mul_pkg::mul_operand_u op_a_dat,
  input  wire logic [1:0]                op_a_nz,
  input  wire logic                      op_a_pvld,
  input  wire mac_mul_pkg::mul_operand_u op_b_dat,
  input  wire logic [1:0]                op_b_nz,
  input  wire logic                      op_b_pvld,
  mul_op_if.src                          op
);

  logic       cfg_is_int8_d1;  // captured mode
  logic [8:0] code_lo;         // digits 0-3
  logic [8:0] code_hi;         // digits 4-7

  // ==========================================================================
  // mode register
  // ==========================================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cfg_is_int8_d1 <= 1'b0;  // int16 out of reset
    end else if (cfg_reg_en) begin
      cfg_is_int8_d1 <= cfg_is_int8;
    end
  end

  assign op.is_int8 = cfg_is_int8_d1;

  // a lane needs both operands valid and non-zero
  assign op.lane_vld[1] = op_a_pvld & op_b_pvld & op_a_nz[1] & op_b_nz[1];
  assign op.lane_vld[0] = op_a_pvld & op_b_pvld & op_a_nz[0] & op_b_nz[0];

  // ==========================================================================
  // booth windows
  // ==========================================================================
  assign code_lo = {op_a_dat.lanes.lo, 1'b0};
  // int8 restarts the high byte, int16 overlaps bit 7
  assign code_hi = cfg_is_int8_d1 ? {op_a_dat.lanes.hi, 1'b0} : op_a_dat.word[15:7];

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      op.code[i]     = code_lo[2*i +: mac_mul_pkg::DIGIT_W];  // overlapping by one bit
      op.code[i + 4] = code_hi[2*i +: mac_mul_pkg::DIGIT_W];
    end
  end

  // b words, zero-extended byte per group in int8
  always_comb begin
    op.src_lo = op_b_dat;
    op.src_hi = op_b_dat;
    if (cfg_is_int8_d1) begin
      op.src_lo.word = {{mac_mul_pkg::LANE_W{1'b0}}, op_b_dat.lanes.lo};
      op.src_hi.word = {{mac_mul_pkg::LANE_W{1'b0}}, op_b_dat.lanes.hi};
    end
  end

endmodule

`default_nettype wire

//--- design/mac_csa_reduce.sv
/*
 * two level carry-save reduction
 * each digit group folds to a 24-bit pair, int16 merges both pairs
 * in a 32-bit tree with the high group eight bits up
 */

`default_nettype none
`timescale 1ns/1ns

module mac_csa_reduce (
  input  wire logic [mac_mul_pkg::ROWS_PER_GROUP-1:0][mac_mul_pkg::PP_W-1:0] rows_lo,
  input  wire logic [mac_mul_pkg::ROWS_PER_GROUP-1:0][mac_mul_pkg::PP_W-1:0] rows_hi,
  input  wire logic                                                          is_int8,
  input  wire logic [1:0]                                                    lane_vld,
  mul_pp_if.src                                                              pp
);

  localparam int unsigned SFT = mac_mul_pkg::RES_W - mac_mul_pkg::PP_W;  // 8

  logic [mac_mul_pkg::PP_W-1:0]        lo_sum;
  logic [mac_mul_pkg::PP_W-1:0]        lo_carry;
  logic [mac_mul_pkg::PP_W-1:0]        hi_sum;
  logic [mac_mul_pkg::PP_W-1:0]        hi_carry;
  logic [3:0][mac_mul_pkg::RES_W-1:0]  l1_rows;

  // ==========================================================================
  // level 0, one tree per group
  // ==========================================================================
  mac_csa_tree #(.N_ROWS(mac_mul_pkg::ROWS_PER_GROUP), .WIDTH(mac_mul_pkg::PP_W)) u_tree_lo (
    .rows  (rows_lo),
    .sum   (lo_sum),
    .carry (lo_carry)
  );

  mac_csa_tree #(.N_ROWS(mac_mul_pkg::ROWS_PER_GROUP), .WIDTH(mac_mul_pkg::PP_W)) u_tree_hi (
    .rows  (rows_hi),
    .sum   (hi_sum),
    .carry (hi_carry)
  );

  // ==========================================================================
  // level 1, int16 only, held at zero in int8 to save toggles
  // ==========================================================================
  assign l1_rows = is_int8 ? '0 :
                   {{hi_carry, {SFT{1'b0}}},
                    {hi_sum,   {SFT{1'b0}}},
                    {{SFT{1'b0}}, lo_carry},
                    {{SFT{1'b0}}, lo_sum}};

  mac_csa_tree #(.N_ROWS(4), .WIDTH(mac_mul_pkg::RES_W)) u_tree_l1 (
    .rows  (l1_rows),
    .sum   (pp.l1_sum),
    .carry (pp.l1_carry)
  );

  assign pp.l0_lo_sum   = lo_sum;
  assign pp.l0_lo_carry = lo_carry;
  assign pp.l0_hi_sum   = hi_sum;
  assign pp.l0_hi_carry = hi_carry;
  assign pp.is_int8     = is_int8;
  assign pp.lane_vld    = lane_vld;

endmodule

`default_nettype wire

//--- design/mac_csa_tree.sv
/*
 * carry-save reduction of N_ROWS rows to a sum/carry pair
 * one 3:2 layer per extra row, computed with guard bits so that
 * sum + carry equals the row total exactly when it fits in WIDTH
 */

`default_nettype none
`timescale 1ns/1ns

module mac_csa_tree #(
  parameter int unsigned N_ROWS = 5,
  parameter int unsigned WIDTH  = 24
) (
  input  wire logic [N_ROWS-1:0][WIDTH-1:0] rows,
  output logic [WIDTH-1:0]                  sum,
  output logic [WIDTH-1:0]                  carry
);

  localparam int unsigned EXT_W = WIDTH + $clog2(N_ROWS);  // room for the full total

  logic [EXT_W-1:0] s_lvl [N_ROWS-1];  // running sum vector
  logic [EXT_W-1:0] c_lvl [N_ROWS-1];  // running carry vector

  assign s_lvl[0] = EXT_W'(rows[0]);
  assign c_lvl[0] = EXT_W'(rows[1]);

  for (genvar k = 1; k < N_ROWS - 1; k++) begin : g_lvl
    logic [EXT_W-1:0] in_c;
    logic [EXT_W-1:0] maj;

    assign in_c     = EXT_W'(rows[k + 1]);
    assign s_lvl[k] = s_lvl[k-1] ^ c_lvl[k-1] ^ in_c;
    assign maj      = (s_lvl[k-1] & c_lvl[k-1]) | (in_c & (s_lvl[k-1] ^ c_lvl[k-1]));
    // top maj bit is always zero, total < 2^EXT_W
    assign c_lvl[k] = {maj[EXT_W-2:0], 1'b0};
  end

  assign sum   = s_lvl[N_ROWS-2][WIDTH-1:0];
  assign carry = c_lvl[N_ROWS-2][WIDTH-1:0];

endmodule

`default_nettype wire

//--- design/mac_mul_if.sv
/*
 * internal bundles of the multiplier lane
 * mul_op_if  carries booth digits and source words into the selector array
 * mul_pp_if  carries the carry-save pairs to the output gating
 */

`default_nettype none
`timescale 1ns/1ns

interface mul_op_if;

  logic [mac_mul_pkg::N_DIGITS-1:0][mac_mul_pkg::DIGIT_W-1:0] code;  // 8 windows
  mac_mul_pkg::mul_operand_u                                  src_lo;  // b for digits 0-3
  mac_mul_pkg::mul_operand_u                                  src_hi;  // b for digits 4-7
  logic                                                       is_int8;
  logic [1:0]                                                 lane_vld;

  modport src (output code, output src_lo, output src_hi, output is_int8, output lane_vld);
  modport dst (input code, input src_lo, input src_hi, input is_int8, input lane_vld);

endinterface

interface mul_pp_if;

  // first level pairs, one per digit group
  logic [mac_mul_pkg::PP_W-1:0]  l0_lo_sum;
  logic [mac_mul_pkg::PP_W-1:0]  l0_lo_carry;
  logic [mac_mul_pkg::PP_W-1:0]  l0_hi_sum;
  logic [mac_mul_pkg::PP_W-1:0]  l0_hi_carry;
  // merged int16 pair
  logic [mac_mul_pkg::RES_W-1:0] l1_sum;
  logic [mac_mul_pkg::RES_W-1:0] l1_carry;
  logic                          is_int8;
  logic [1:0]                    lane_vld;

  modport src (
    output l0_lo_sum, output l0_lo_carry, output l0_hi_sum, output l0_hi_carry,
    output l1_sum, output l1_carry, output is_int8, output lane_vld
  );
  modport dst (
    input l0_lo_sum, input l0_lo_carry, input l0_hi_sum, input l0_hi_carry,
    input l1_sum, input l1_carry, input is_int8, input lane_vld
  );

endinterface

`default_nettype wire

//--- design/mac_mul_pkg.sv
/*
 * shared constants for the signed booth multiplier lane
 * widths, bias words and the operand word union
 * int16 mode is one 16x16 multiply, int8 mode two 8x8 byte multiplies
 */

`default_nettype none

package mac_mul_pkg;

  localparam int unsigned OP_W           = 16;  // operand width
  localparam int unsigned LANE_W         = 8;   // int8 byte lane
  localparam int unsigned N_DIGITS       = 8;   // radix-4 digits, 0-3 low group, 4-7 high
  localparam int unsigned DIGIT_W        = 3;   // booth window
  localparam int unsigned SEL_W          = 17;  // selector output, top bit inverted sign
  localparam int unsigned ROWS_PER_GROUP = 5;   // 4 multiples + 1 trailing inv bit row
  localparam int unsigned PP_W           = 24;  // first level row width
  localparam int unsigned RES_W          = 32;  // result width

  // implicit 2^16 per row, weights 1+4+16+64 = 85 per group
  // high group sits 8 bits up, so 0x55 shows in both bytes
  localparam logic [RES_W-1:0] BIAS_INT16 = 32'h5555_0000;
  // same 85 x 2^8 per byte lane, one copy per 16-bit half
  localparam logic [RES_W-1:0] BIAS_INT8  = 32'h5500_5500;

  // operand word, read as one int16 or as two int8 bytes
  typedef union packed {
    logic [OP_W-1:0] word;
    struct packed {
      logic [LANE_W-1:0] hi;  // lane 1
      logic [LANE_W-1:0] lo;  // lane 0
    } lanes;
  } mul_operand_u;

endpackage

`default_nettype wire

//--- design/mac_mul_top.sv
/*
 * signed booth multiplier lane, top level
 * int16 or dual int8 product as a carry-save pair with bias
 */

`default_nettype none
`timescale 1ns/1ns

module mac_mul_top (
  input  wire logic                           nvdla_core_clk,
  input  wire logic                           nvdla_core_rstn,
  input  wire logic                           cfg_is_int8,
  input  wire logic                           cfg_reg_en,
  input  wire logic [mac_mul_pkg::OP_W-1:0]   op_a_dat,
  input  wire logic [1:0]                     op_a_nz,
  input  wire logic                           op_a_pvld,
  input  wire logic [mac_mul_pkg::OP_W-1:0]   op_b_dat,
  input  wire logic [1:0]                     op_b_nz,
  input  wire logic                           op_b_pvld,
  output logic [mac_mul_pkg::RES_W-1:0]       res_a,
  output logic [mac_mul_pkg::RES_W-1:0]       res_b
);

  logic [mac_mul_pkg::ROWS_PER_GROUP-1:0][mac_mul_pkg::PP_W-1:0] rows_lo;
  logic [mac_mul_pkg::ROWS_PER_GROUP-1:0][mac_mul_pkg::PP_W-1:0] rows_hi;
  logic                                                          pp_is_int8;
  logic [1:0]                                                    pp_lane_vld;

  mul_op_if op_if ();
  mul_pp_if pp_if ();

  mac_cfg_op u_cfg_op (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg_is_int8     (cfg_is_int8),
    .cfg_reg_en      (cfg_reg_en),
    .op_a_dat        (op_a_dat),
    .op_a_nz         (op_a_nz),
    .op_a_pvld       (op_a_pvld),
    .op_b_dat        (op_b_dat),
    .op_b_nz         (op_b_nz),
    .op_b_pvld       (op_b_pvld),
    .op              (op_if.src)
  );

  mac_pp_array u_pp_array (
    .op       (op_if.dst),
    .rows_lo  (rows_lo),
    .rows_hi  (rows_hi),
    .is_int8  (pp_is_int8),
    .lane_vld (pp_lane_vld)
  );

  mac_csa_reduce u_csa_reduce (
    .rows_lo  (rows_lo),
    .rows_hi  (rows_hi),
    .is_int8  (pp_is_int8),
    .lane_vld (pp_lane_vld),
    .pp       (pp_if.src)
  );

  mac_res_gate u_res_gate (
    .pp    (pp_if.dst),
    .res_a (res_a),
    .res_b (res_b)
  );

endmodule

`default_nettype wire

//--- design/mac_pp_array.sv
/*
 * partial product array
 * eight booth selectors, outputs placed at a two-bit step into
 * two groups of five rows, inversion bits fill the gap of the next row
 */

`default_nettype none
`timescale 1ns/1ns

module mac_pp_array (
  mul_op_if.dst op,
  output logic [mac_mul_pkg::ROWS_PER_GROUP-1:0][mac_mul_pkg::PP_W-1:0] rows_lo,
  output logic [mac_mul_pkg::ROWS_PER_GROUP-1:0][mac_mul_pkg::PP_W-1:0] rows_hi,
  output logic                                                          is_int8,
  output logic [1:0]                                                    lane_vld
);

  logic [mac_mul_pkg::N_DIGITS-1:0][mac_mul_pkg::SEL_W-1:0] sel_data;
  logic [mac_mul_pkg::N_DIGITS-1:0]                         sel_inv;

  for (genvar i = 0; i < mac_mul_pkg::N_DIGITS; i++) begin : g_sel
    mac_booth_sel u_sel (
      .code     (op.code[i]),
      .is_int8  (op.is_int8),
      .src      ((i < mac_mul_pkg::N_DIGITS / 2) ? op.src_lo : op.src_hi),
      .sel_data (sel_data[i]),
      .sel_inv  (sel_inv[i])
    );
  end

  // ==========================================================================
  // row placement
  // ==========================================================================
  always_comb begin
    rows_lo = '0;
    rows_hi = '0;
    for (int j = 0; j < 4; j++) begin
      rows_lo[j][2*j +: mac_mul_pkg::SEL_W] = sel_data[j];
      rows_hi[j][2*j +: mac_mul_pkg::SEL_W] = sel_data[j + 4];
      // +1 of digit j sits at weight 2j, in row j+1 (row 4 for the last)
      rows_lo[j + 1][2*j] = sel_inv[j];
      rows_hi[j + 1][2*j] = sel_inv[j + 4];
    end
  end

  assign is_int8  = op.is_int8;
  assign lane_vld = op.lane_vld;

endmodule

`default_nettype wire

//--- design/mac_res_gate.sv
/*
 * output side, picks the pair for the mode and gates
 * each invalid 16-bit half to the bias pattern
 */

`default_nettype none
`timescale 1ns/1ns

module mac_res_gate (
  mul_pp_if.dst                          pp,
  output logic [mac_mul_pkg::RES_W-1:0]  res_a,
  output logic [mac_mul_pkg::RES_W-1:0]  res_b
);

  logic [mac_mul_pkg::RES_W-1:0] res_a_ori;
  logic [mac_mul_pkg::RES_W-1:0] res_b_ori;
  logic [mac_mul_pkg::RES_W-1:0] bias;  // zero product pattern

  // int8 packs the low halves of both group pairs
  assign res_a_ori = pp.is_int8 ? {pp.l0_hi_sum[15:0], pp.l0_lo_sum[15:0]} : pp.l1_sum;
  assign res_b_ori = pp.is_int8 ? {pp.l0_hi_carry[15:0], pp.l0_lo_carry[15:0]} : pp.l1_carry;

  assign bias = pp.is_int8 ? mac_mul_pkg::BIAS_INT8 : mac_mul_pkg::BIAS_INT16;

  always_comb begin
    res_a[31:16] = pp.lane_vld[1] ? res_a_ori[31:16] : bias[31:16];
    res_a[15:0]  = pp.lane_vld[0] ? res_a_ori[15:0]  : bias[15:0];
    res_b[31:16] = pp.lane_vld[1] ? res_b_ori[31:16] : 16'h0000;  // bias only in a
    res_b[15:0]  = pp.lane_vld[0] ? res_b_ori[15:0]  : 16'h0000;
  end

endmodule

`default_nettype wire

//--- mac_mul.f
design/mac_mul_pkg.sv
design/mac_mul_if.sv
design/mac_cfg_op.sv
design/mac_booth_sel.sv
design/mac_pp_array.sv
design/mac_csa_tree.sv
design/mac_csa_reduce.sv
design/mac_res_gate.sv
design/mac_mul_top.sv
tb/tb_mac_mul.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the multiplier lane testbench with verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_mac_mul \
  -f mac_mul.f \
  -o sim_mac_mul

./obj_dir/sim_mac_mul 2>&1 | tee "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi

//--- tb/mac_mul_stim.txt
// en mode op_a op_b a_nz b_nz a_pvld b_pvld expected_sum
// expected_sum is res_a+res_b, whole word in int16, per 16-bit half in int8
0 0 0000 0000 3 3 1 1 55550000
0 0 0001 0001 3 3 1 1 55550001
0 0 ffff 0001 3 3 1 1 5554ffff
0 0 ffff ffff 3 3 1 1 55550001
0 0 7fff 7fff 3 3 1 1 95540001
0 0 8000 8000 3 3 1 1 95550000
0 0 8000 7fff 3 3 1 1 15558000
0 0 1234 fedc 3 3 1 1 55403cb0
0 0 ff38 0064 3 3 1 1 5554b1e0
0 0 0003 8001 3 3 1 1 55538003
0 0 1234 5678 3 3 0 1 55550000
0 1 0202 0303 3 3 1 1 555b0c06
0 1 ff00 0100 3 3 1 1 55540000
1 1 0202 0303 3 3 1 1 55065506
0 1 8080 8080 3 3 1 1 95009500
0 1 7f81 fd05 3 3 1 1 53835285
0 1 c803 0bf6 3 3 1 1 529854e2
0 1 807f 7f80 3 3 1 1 15801580
0 1 0505 0707 1 3 1 1 55005523
0 1 fe09 0304 3 2 1 1 54fa5500
0 1 7f7f 7f7f 3 3 1 0 55005500
0 1 8080 8080 3 3 0 0 55005500
0 0 0202 0303 3 3 1 1 55065506
1 0 0202 0303 3 3 1 1 555b0c06
0 0 ffff 8000 3 3 1 1 55558000
0 0 1234 1234 0 3 1 1 55550000

//--- tb/tb_mac_mul.sv
/*
 * testbench for the signed booth multiplier lane
 * reads vectors from the stim file, drives them on the falling edge
 * and checks the folded carry-save pair on the next falling edge
 */

`default_nettype none
`timescale 1ns/1ns

module tb_mac_mul;

  localparam int CLK_PERIOD = 100;
  localparam int RST_CYCLES = 8;
  localparam int N_FIELDS   = 9;   // en mode a b a_nz b_nz a_pvld b_pvld exp
  localparam int MAX_VEC    = 64;
  // 85 x 2^16 per digit group, high group 8 bits up
  localparam logic [31:0] BIAS16 = 32'h5555_0000;

  logic        nvdla_core_clk;
  logic        nvdla_core_rstn;
  logic        cfg_is_int8;
  logic        cfg_reg_en;
  logic [15:0] op_a_dat;
  logic [1:0]  op_a_nz;
  logic        op_a_pvld;
  logic [15:0] op_b_dat;
  logic [1:0]  op_b_nz;
  logic        op_b_pvld;
  logic [31:0] res_a;
  logic [31:0] res_b;

  logic [31:0] stim [N_FIELDS*MAX_VEC];  // flat, N_FIELDS words per vector
  int          n_vec;
  logic        stim_loaded;
  logic        mode_int8;                 // model of the mode register

  mac_mul_top dut0 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg_is_int8     (cfg_is_int8),
    .cfg_reg_en      (cfg_reg_en),
    .op_a_dat        (op_a_dat),
    .op_a_nz         (op_a_nz),
    .op_a_pvld       (op_a_pvld),
    .op_b_dat        (op_b_dat),
    .op_b_nz         (op_b_nz),
    .op_b_pvld       (op_b_pvld),
    .res_a           (res_a),
    .res_b           (res_b)
  );

  always #(CLK_PERIOD/2) nvdla_core_clk = ~nvdla_core_clk;

  // ==========================================================================
  // helpers
  // ==========================================================================
  // carry-save pair to a plain word, per half in int8
  function automatic logic [31:0] fold_pair(input logic is_int8, input logic [31:0] a,
                                            input logic [31:0] b);
    if (is_int8)
      return {a[31:16] + b[31:16], a[15:0] + b[15:0]};
    return a + b;
  endfunction

  task automatic drive_vec(input int idx);
    int base;
    base        = idx * N_FIELDS;
    cfg_reg_en  = stim[base][0];
    cfg_is_int8 = stim[base+1][0];
    op_a_dat    = stim[base+2][15:0];
    op_b_dat    = stim[base+3][15:0];
    op_a_nz     = stim[base+4][1:0];
    op_b_nz     = stim[base+5][1:0];
    op_a_pvld   = stim[base+6][0];
    op_b_pvld   = stim[base+7][0];
    if (stim[base][0])
      mode_int8 = stim[base+1][0];  // loads at the coming rising edge
  endtask

  task automatic check_vec(input int idx);
    int          base;
    string       name;
    logic [31:0] exp_sum;
    logic [31:0] got_sum;
    logic [1:0]  lane_vld;
    base     = idx * N_FIELDS;
    name     = $sformatf("vector %0d", idx);
    exp_sum  = stim[base+8];
    got_sum  = fold_pair(mode_int8, res_a, res_b);
    // lane valid needs both pvld and both nz bits
    lane_vld = {2{stim[base+6][0] & stim[base+7][0]}} & stim[base+4][1:0] & stim[base+5][1:0];
    assert (got_sum == exp_sum) else begin
      $display("Mismatch %s expected %h actual %h", name, exp_sum, got_sum);
      $display("Simulation FAILED");
      $fatal(1);
    end
    for (int k = 0; k < 2; k++) begin
      if (!lane_vld[k]) begin
        assert (res_b[16*k +: 16] == 16'h0000) else begin  // gated half has no carry word
          $display("Mismatch %s res_b half %0d expected %h actual %h",
                   name, k, 16'h0000, res_b[16*k +: 16]);
          $display("Simulation FAILED");
          $fatal(1);
        end
      end
    end
  endtask

  task automatic check_reset();
    assert (res_a == BIAS16) else begin
      $display("Mismatch reset res_a expected %h actual %h", BIAS16, res_a);
      $display("Simulation FAILED");
      $fatal(1);
    end
    assert (res_b == 32'h0) else begin
      $display("Mismatch reset res_b expected %h actual %h", 32'h0, res_b);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================
  initial begin
    nvdla_core_clk  = 1'b0;
    nvdla_core_rstn = 1'b0;
    cfg_is_int8     = 1'b0;
    cfg_reg_en      = 1'b0;
    op_a_dat        = 16'h0;
    op_a_nz         = 2'b00;
    op_a_pvld       = 1'b0;
    op_b_dat        = 16'h0;
    op_b_nz         = 2'b00;
    op_b_pvld       = 1'b0;
    mode_int8       = 1'b0;  // int16 out of reset
    stim_loaded     = 1'b0;
    n_vec           = 0;
    for (int i = 0; i < N_FIELDS * MAX_VEC; i++)
      stim[i] = '1;          // marks the end of the file
    $readmemh("tb/mac_mul_stim.txt", stim);
    while (n_vec < MAX_VEC && stim[n_vec * N_FIELDS] != 32'hffff_ffff)
      n_vec++;
    if (n_vec == 0) begin
      $display("no vectors were found in the stim file");
      $display("Simulation FAILED");
      $fatal(1);
    end
    stim_loaded = 1'b1;

    repeat (RST_CYCLES) @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
    @(negedge nvdla_core_clk);
    check_reset();           // valids still low

    for (int v = 0; v < n_vec; v++) begin
      drive_vec(v);
      @(negedge nvdla_core_clk);
      check_vec(v);
    end

    $display("Simulation PASSED");
    $finish;
  end

  // watchdog, sized from the vector count
  initial begin
    wait (stim_loaded === 1'b1);
    #((n_vec + RST_CYCLES + 20) * CLK_PERIOD);
    $display("the run did not finish within the time allowed for %0d vectors", n_vec);
    $display("Simulation FAILED");
    $fatal(1);
  end

endmodule

`default_nettype wire
